/* verilog/bus_pkg.sv */
package bus_pkg;

  // master side byte address and bus word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // one enable per byte lane of data_t
  typedef logic [3:0] be_t;

  // word index inside a slave window
  typedef logic [9:0] word_idx_t;

  typedef enum logic [1:0] {
    sel_none = 2'd0,
    sel_fast = 2'd1,
    sel_slow = 2'd2,
    sel_io   = 2'd3
  } slave_sel_e;

  // registers of the io block, one word each
  typedef enum logic [1:0] {
    reg_scratch = 2'd0,
    reg_reload  = 2'd1,
    reg_control = 2'd2,
    reg_status  = 2'd3
  } io_reg_e;

  // address map
  localparam addr_t fast_ram_base = 32'h0000_0000;
  localparam addr_t slow_ram_base = 32'h0001_0000;
  localparam addr_t io_base       = 32'h0002_0000;

  localparam addr_t ram_window = 32'h0000_1000;
  localparam addr_t io_window  = 32'h0000_0010;

  // control register bits
  localparam int ctrl_enable_bit = 0;
  localparam int ctrl_irq_en_bit = 1;

  // status register bits
  localparam int status_pending_bit = 0;

endpackage

/* verilog/bus_if.sv */
`timescale 1ns/1ps

interface bus_if import bus_pkg::*; ();

  // common timing base handed out by the decoder
  logic sysclock;
  logic rst_n;

  logic      read;
  logic      write;
  word_idx_t address;
  data_t     writedata;
  be_t       byteenable;
  data_t     readdata;
  logic      waitrequest;

  modport host (
    output sysclock, rst_n,
    output read, write, address, writedata, byteenable,
    input  readdata, waitrequest
  );

  modport target (
    input  sysclock, rst_n,
    input  read, write, address, writedata, byteenable,
    output readdata, waitrequest
  );

endinterface

/* verilog/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder import bus_pkg::*; (
  input  logic       sysclock,
  input  logic       rst_n,
  input  addr_t      address,
  input  logic       read,
  input  logic       write,
  input  data_t      writedata,
  input  be_t        byteenable,
  output slave_sel_e sel,
  output logic       fault,
  bus_if.host        fast_port,
  bus_if.host        slow_port,
  bus_if.host        io_port
);

  addr_t     offset;
  word_idx_t word_index;
  logic      strobe;

  assign strobe = read | write;

  // window compare, unsigned wrap keeps addresses below a base out
  always_comb begin
    sel = sel_none;
    offset = '0;
    if ((address - fast_ram_base) < ram_window) begin
      sel = sel_fast;
      offset = address - fast_ram_base;
    end else if ((address - slow_ram_base) < ram_window) begin
      sel = sel_slow;
      offset = address - slow_ram_base;
    end else if ((address - io_base) < io_window) begin
      sel = sel_io;
      offset = address - io_base;
    end
  end

  // byte offset to word index, io offsets leave the upper bits zero
  assign word_index = offset[11:2];

  assign fault = strobe & (sel == sel_none);

  // clock and reset shared by all slave ports
  assign fast_port.sysclock = sysclock;
  assign fast_port.rst_n    = rst_n;
  assign slow_port.sysclock = sysclock;
  assign slow_port.rst_n    = rst_n;
  assign io_port.sysclock   = sysclock;
  assign io_port.rst_n      = rst_n;

  // strobes only reach the selected slave
  assign fast_port.read  = read  & (sel == sel_fast);
  assign fast_port.write = write & (sel == sel_fast);
  assign slow_port.read  = read  & (sel == sel_slow);
  assign slow_port.write = write & (sel == sel_slow);
  assign io_port.read    = read  & (sel == sel_io);
  assign io_port.write   = write & (sel == sel_io);

  assign fast_port.address    = word_index;
  assign fast_port.writedata  = writedata;
  assign fast_port.byteenable = byteenable;
  assign slow_port.address    = word_index;
  assign slow_port.writedata  = writedata;
  assign slow_port.byteenable = byteenable;
  assign io_port.address      = word_index;
  assign io_port.writedata    = writedata;
  assign io_port.byteenable   = byteenable;

endmodule

/* verilog/wait_state_ram.sv */
`timescale 1ns/1ps

module wait_state_ram import bus_pkg::*; #(
  parameter int DEPTH       = 1024,
  parameter int WAIT_CYCLES = 0
) (
  input  logic  sysclock,
  input  logic  rst_n,
  bus_if.target port
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(WAIT_CYCLES + 2);

  // counter value of the completing cycle
  localparam logic [CW-1:0] LAST = CW'(WAIT_CYCLES + 1);

  data_t mem [DEPTH];
  data_t rdata_q;

  logic [CW-1:0] wait_cnt;
  logic [AW-1:0] index;
  logic          strobe;
  logic          done;

  assign index  = port.address[AW-1:0];
  assign strobe = port.read | port.write;
  assign done   = strobe & (wait_cnt == LAST);

  // one count per cycle of an access, rearm on completion
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!strobe || done) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // byte lane merge on the completing cycle
  always_ff @(posedge sysclock) begin
    if (port.write && done) begin
      for (int b = 0; b < $bits(be_t); b++) begin
        if (port.byteenable[b]) begin
          mem[index][b*8 +: 8] <= port.writedata[b*8 +: 8];
        end
      end
    end
  end

  // address is held stable, so the word is in place by completion
  always_ff @(posedge sysclock) begin
    if (port.read) begin
      rdata_q <= mem[index];
    end
  end

  assign port.readdata    = rdata_q;
  assign port.waitrequest = ~done;

endmodule

/* verilog/io_regs.sv */
`timescale 1ns/1ps

module io_regs import bus_pkg::*; (
  input  logic  sysclock,
  input  logic  rst_n,
  bus_if.target port,
  output logic  timer_pending,
  output logic  timer_irq_en
);

  data_t      scratch_q;
  data_t      reload_q;
  data_t      count_q;
  logic [1:0] control_q;
  logic       pending_q;
  io_reg_e    reg_sel;
  logic       timer_en;

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < $bits(be_t); b++) begin
      if (be[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  assign reg_sel  = io_reg_e'(port.address[1:0]);
  assign timer_en = control_q[ctrl_enable_bit];

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      scratch_q <= '0;
      reload_q  <= '0;
      control_q <= '0;
    end else if (port.write) begin
      case (reg_sel)
        reg_scratch: scratch_q <= merge_bytes(scratch_q, port.writedata, port.byteenable);
        reg_reload:  reload_q  <= merge_bytes(reload_q, port.writedata, port.byteenable);
        reg_control: control_q <= port.writedata[1:0];
        default: ;
      endcase
    end
  end

  // countdown follows reload while the timer is off
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (!timer_en || count_q == '0) begin
      count_q <= reload_q;
    end else begin
      count_q <= count_q - 1'b1;
    end
  end

  // write one to clear, a new expiry in the same cycle wins
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else begin
      if (port.write && reg_sel == reg_status && port.writedata[status_pending_bit]) begin
        pending_q <= 1'b0;
      end
      if (timer_en && count_q == '0) begin
        pending_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (reg_sel)
      reg_scratch: port.readdata = scratch_q;
      reg_reload:  port.readdata = reload_q;
      reg_control: port.readdata = {30'b0, control_q};
      default:     port.readdata = {31'b0, pending_q};
    endcase
  end

  // single cycle slave
  assign port.waitrequest = 1'b0;

  assign timer_pending = pending_q;
  assign timer_irq_en  = control_q[ctrl_irq_en_bit];

endmodule

/* verilog/response_mux.sv */
`timescale 1ns/1ps

module response_mux import bus_pkg::*; (
  input  slave_sel_e sel,
  input  logic       fault,
  bus_if.host        fast_port,
  bus_if.host        slow_port,
  bus_if.host        io_port,
  input  logic       timer_pending,
  input  logic       timer_irq_en,
  output data_t      readdata,
  output logic       waitrequest,
  output logic       irq
);

  always_comb begin
    case (sel)
      sel_fast: begin
        readdata    = fast_port.readdata;
        waitrequest = fast_port.waitrequest;
      end
      sel_slow: begin
        readdata    = slow_port.readdata;
        waitrequest = slow_port.waitrequest;
      end
      sel_io: begin
        readdata    = io_port.readdata;
        waitrequest = io_port.waitrequest;
      end
      default: begin
        // unmapped, finish at once with zero data
        readdata    = '0;
        waitrequest = 1'b0;
      end
    endcase
  end

  // fault takes priority over the timer interrupt
  assign irq = timer_pending & timer_irq_en & ~fault;

endmodule

/* verilog/bus_fabric.sv */
`timescale 1ns/1ps

module bus_fabric import bus_pkg::*; #(
  parameter int RAM_WORDS = 1024,
  parameter int SLOW_WAIT = 3
) (
  input  logic  sysclock,
  input  logic  rst_n,
  input  addr_t address,
  input  logic  read,
  input  logic  write,
  input  data_t writedata,
  input  be_t   byteenable,
  output data_t readdata,
  output logic  waitrequest,
  output logic  fault,
  output logic  irq
);

  slave_sel_e sel;
  logic       timer_pending;
  logic       timer_irq_en;

  bus_if fast_bus ();
  bus_if slow_bus ();
  bus_if io_bus ();

  bus_decoder decoder (
    .sysclock   (sysclock),
    .rst_n      (rst_n),
    .address    (address),
    .read       (read),
    .write      (write),
    .writedata  (writedata),
    .byteenable (byteenable),
    .sel        (sel),
    .fault      (fault),
    .fast_port  (fast_bus.host),
    .slow_port  (slow_bus.host),
    .io_port    (io_bus.host)
  );

  // slaves run on the clock and reset carried by their port
  wait_state_ram #(
    .DEPTH       (RAM_WORDS),
    .WAIT_CYCLES (0)
  ) fast_ram (
    .sysclock (fast_bus.sysclock),
    .rst_n    (fast_bus.rst_n),
    .port     (fast_bus.target)
  );

  wait_state_ram #(
    .DEPTH       (RAM_WORDS),
    .WAIT_CYCLES (SLOW_WAIT)
  ) slow_ram (
    .sysclock (slow_bus.sysclock),
    .rst_n    (slow_bus.rst_n),
    .port     (slow_bus.target)
  );

  io_regs io (
    .sysclock      (io_bus.sysclock),
    .rst_n         (io_bus.rst_n),
    .port          (io_bus.target),
    .timer_pending (timer_pending),
    .timer_irq_en  (timer_irq_en)
  );

  response_mux resp (
    .sel           (sel),
    .fault         (fault),
    .fast_port     (fast_bus.host),
    .slow_port     (slow_bus.host),
    .io_port       (io_bus.host),
    .timer_pending (timer_pending),
    .timer_irq_en  (timer_irq_en),
    .readdata      (readdata),
    .waitrequest   (waitrequest),
    .irq           (irq)
  );

endmodule

/* verification/tb_bus_fabric.sv */
`timescale 1ns/1ps

module tb_bus_fabric import bus_pkg::*; ();

  localparam int RAM_WORDS  = 1024;
  localparam int SLOW_WAIT  = 3;
  localparam int MAX_LINES  = 64;
  localparam int FIELDS     = 6;
  localparam int FILL_WORDS = 32;
  localparam addr_t FILL_BASE = 32'h0000_0800;
  localparam logic [31:0] SEED = 32'h01f4de6f;

  logic  sysclock;
  logic  rst_n;
  addr_t address;
  logic  read;
  logic  write;
  data_t writedata;
  be_t   byteenable;
  data_t readdata;
  logic  waitrequest;
  logic  fault;
  logic  irq;

  logic [31:0] stim [MAX_LINES*FIELDS];

  int   value_errors  = 0;
  int   timing_errors = 0;
  int   other_errors  = 0;
  int   cycle_count   = 0;
  int   cycle_limit   = 100000;
  logic irq_en_shadow = 1'b0;

  bus_fabric #(
    .RAM_WORDS (RAM_WORDS),
    .SLOW_WAIT (SLOW_WAIT)
  ) dut (
    .sysclock    (sysclock),
    .rst_n       (rst_n),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .fault       (fault),
    .irq         (irq)
  );

  initial begin
    sysclock = 1'b0;
    forever #5 sysclock = ~sysclock;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // access length from the address map and wait rules
  function automatic int expected_cycles(input addr_t addr);
    if (addr >= fast_ram_base && addr < fast_ram_base + ram_window) begin
      return 2;
    end
    if (addr >= slow_ram_base && addr < slow_ram_base + ram_window) begin
      return SLOW_WAIT + 2;
    end
    return 1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("[ERROR] %s cycles expected %0d actual %0d", name, expected, actual);
      timing_errors++;
    end
  endtask

  // one access with the response sampled in the cycle waitrequest is low
  task automatic bus_access(input logic is_write, input addr_t addr, input data_t data,
                            input be_t be, output data_t rdata, output logic flt,
                            output logic irq_seen, output int cycles);
    @(negedge sysclock);
    address    = addr;
    read       = ~is_write;
    write      = is_write;
    writedata  = data;
    byteenable = be;
    cycles     = 0;
    do begin
      @(posedge sysclock);
      cycles++;
    end while (waitrequest);
    rdata    = readdata;
    flt      = fault;
    irq_seen = irq;
    @(negedge sysclock);
    read  = 1'b0;
    write = 1'b0;
  endtask

  task automatic wait_for_irq(input int bound, output int cycles);
    cycles = 0;
    do begin
      @(posedge sysclock);
      cycles++;
    end while (!irq && cycles <= bound);
  endtask

  task automatic run_line(input int n);
    logic [31:0] op;
    addr_t       addr;
    data_t       data;
    be_t         be;
    logic [31:0] expected;
    logic        exp_fault;
    data_t       rdata;
    logic        flt;
    logic        irq_seen;
    int          cycles;
    string       name;
    op        = stim[n*FIELDS];
    addr      = stim[n*FIELDS+1];
    data      = stim[n*FIELDS+2];
    be        = stim[n*FIELDS+3][3:0];
    expected  = stim[n*FIELDS+4];
    exp_fault = stim[n*FIELDS+5][0];
    name      = $sformatf("line %0d", n + 1);
    assert (op <= 32'd2) else begin
      $display("%s: unknown operation code %h in the data file", name, op);
      other_errors++;
    end
    if (op == 32'd0 || op == 32'd1) begin
      bus_access(op == 32'd0, addr, data, be, rdata, flt, irq_seen, cycles);
      check_cycles(name, expected_cycles(addr), cycles);
      check_value({name, " fault"}, {31'b0, exp_fault}, {31'b0, flt});
      if (op == 32'd1) begin
        check_value({name, " readdata"}, expected, rdata);
      end
      if (exp_fault) begin
        check_value({name, " irq"}, 32'd0, {31'b0, irq_seen});
      end else if (op == 32'd1 && addr == io_base + 4 * reg_status) begin
        // irq follows pending gated by the last written enable
        check_value({name, " irq"}, {31'b0, expected[status_pending_bit] & irq_en_shadow},
                    {31'b0, irq_seen});
      end
      if (op == 32'd0 && addr == io_base + 4 * reg_control && be[0]) begin
        irq_en_shadow = data[ctrl_irq_en_bit];
      end
    end else if (op == 32'd2) begin
      wait_for_irq(int'(expected), cycles);
      assert (irq && cycles <= int'(expected)) else begin
        $display("%s: irq did not rise within %0d cycles of enabling the timer",
                 name, expected);
        timing_errors++;
      end
    end
  endtask

  initial begin
    logic [31:0] state;
    int          lines;
    int          max_reload;
    data_t       rdata;
    logic        flt;
    logic        irq_seen;
    int          cycles;
    rst_n      = 1'b0;
    address    = '0;
    read       = 1'b0;
    write      = 1'b0;
    writedata  = '0;
    byteenable = '0;
    // entries past the end of the file keep this marker in the upper half
    foreach (stim[i]) begin
      stim[i] = {16'hffff, 16'(i)};
    end
    $readmemh("verification/bus_testdata.txt", stim);
    lines = 0;
    while (lines < MAX_LINES && stim[lines*FIELDS][31:16] != 16'hffff) begin
      lines++;
    end
    max_reload = 0;
    for (int n = 0; n < lines; n++) begin
      if (stim[n*FIELDS] == 0 && stim[n*FIELDS+1] == io_base + 4 * reg_reload &&
          int'(stim[n*FIELDS+2]) > max_reload) begin
        max_reload = int'(stim[n*FIELDS+2]);
      end
    end
    cycle_limit = (lines + 2 * FILL_WORDS) * (SLOW_WAIT + 4) + 2 * max_reload + 100;
    assert (lines > 0) else begin
      $display("no stimulus lines were read from the data file");
      other_errors++;
    end
    repeat (3) @(posedge sysclock);
    @(negedge sysclock);
    rst_n = 1'b1;
    for (int n = 0; n < lines; n++) begin
      run_line(n);
    end
    // random fill of fast ram and readback of the same sequence
    state = SEED;
    for (int i = 0; i < FILL_WORDS; i++) begin
      state = lcg_next(state);
      bus_access(1'b1, FILL_BASE + 4 * i, state, 4'hf, rdata, flt, irq_seen, cycles);
      check_cycles($sformatf("fill write %0d", i), 2, cycles);
    end
    state = SEED;
    for (int i = 0; i < FILL_WORDS; i++) begin
      state = lcg_next(state);
      bus_access(1'b0, FILL_BASE + 4 * i, '0, 4'hf, rdata, flt, irq_seen, cycles);
      check_value($sformatf("fill read %0d", i), state, rdata);
      check_cycles($sformatf("fill read %0d", i), 2, cycles);
    end
    $display("errors: value %0d, timing %0d, other %0d",
             value_errors, timing_errors, other_errors);
    if (value_errors + timing_errors + other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    while (cycle_count <= cycle_limit) begin
      @(posedge sysclock);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* verification/bus_testdata.txt */
// op addr data byteenable expected fault, all hex
// op 0 write, 1 read, 2 wait for irq with expected as the cycle bound
0 00000000 11223344 f 00000000 0
1 00000000 00000000 f 11223344 0
0 00000004 cafebabe f 00000000 0
0 00000004 000055aa 3 00000000 0
1 00000004 00000000 f cafe55aa 0
0 00000ffc 0badf00d f 00000000 0
1 00000ffc 00000000 f 0badf00d 0
0 00010010 deadbeef f 00000000 0
0 00010010 a5000000 8 00000000 0
1 00010010 00000000 f a5adbeef 0
0 00010020 12345678 f 00000000 0
1 00010020 00000000 f 12345678 0
0 00001000 ffffffff f 00000000 1
1 00001000 00000000 f 00000000 1
1 00000000 00000000 f 11223344 0
0 00030000 ffffffff f 00000000 1
0 00020000 89abcdef f 00000000 0
0 00020000 00003300 2 00000000 0
1 00020000 00000000 f 89ab33ef 0
0 00020004 00000014 f 00000000 0
1 00020004 00000000 f 00000014 0
0 00020008 00000003 f 00000000 0
2 00000000 00000000 0 00000016 0
1 0002000c 00000000 f 00000001 0
1 00020010 00000000 f 00000000 1
0 0002000c 00000001 f 00000000 0
1 0002000c 00000000 f 00000000 0
0 00020008 00000000 f 00000000 0

/* sources.f */
verilog/bus_pkg.sv
verilog/bus_if.sv
verilog/bus_decoder.sv
verilog/wait_state_ram.sv
verilog/io_regs.sv
verilog/response_mux.sv
verilog/bus_fabric.sv
verification/tb_bus_fabric.sv

/* Bender.yml */
package:
  name: bus_fabric

sources:
  - files:
      - verilog/bus_pkg.sv
      - verilog/bus_if.sv
      - verilog/bus_decoder.sv
      - verilog/wait_state_ram.sv
      - verilog/io_regs.sv
      - verilog/response_mux.sv
      - verilog/bus_fabric.sv
  - target: test
    files:
      - verification/tb_bus_fabric.sv
